// ==== flist.f ====
+incdir+rtl
rtl/hdmi_tx_pkg.sv
rtl/video_timing_if.sv
rtl/video_timing_gen.sv
rtl/test_pattern_gen.sv
rtl/embedded_sync_inserter.sv
rtl/hdmi_tx_top.sv
testbench/hdmi_tx_checker.sv
testbench/hdmi_tx_tb.sv

// ==== rtl/embedded_sync_inserter.sv ====
/* Six-stage video delay with EAV and SAV preamble insertion */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module embedded_sync_inserter (
  input  logic                        hdmi_clk,
  input  logic                        rst_n,
  input  logic                        hs_de_p,
  input  logic                        vs_de_p,
  input  logic [`HDMI_DATA_WIDTH-1:0] data_p,
  output logic                        hdmi_hs_de,
  output logic                        hdmi_vs_de,
  output logic [`HDMI_DATA_WIDTH-1:0] hdmi_data
);

  // Index 1 is the first stage and 5 the last before the output
  logic [5:1]                         hs_dly;
  logic [5:1]                         vs_dly;
  logic [5:1][`HDMI_DATA_WIDTH-1:0]   data_dly;

  logic [4:0]                         eav_pat;
  logic [4:0]                         sav_pat;
  logic [`HDMI_DATA_WIDTH-1:0]        sav_word;
  logic [`HDMI_DATA_WIDTH-1:0]        eav_word;
  logic [`HDMI_DATA_WIDTH-1:0]        stage1_word;
  logic [`HDMI_DATA_WIDTH-1:0]        out_word;

  // Code bytes follow the vertical enable
  assign sav_word = hdmi_tx_pkg::fill_byte(vs_de_p ? hdmi_tx_pkg::SAV_ACTIVE
                                                   : hdmi_tx_pkg::SAV_BLANK);
  assign eav_word = hdmi_tx_pkg::fill_byte(vs_de_p ? hdmi_tx_pkg::EAV_ACTIVE
                                                   : hdmi_tx_pkg::EAV_BLANK);

  assign eav_pat = {hs_dly[4:1], hs_de_p};
  assign sav_pat = hs_dly[5:1];

  // EAV preamble over the first blank words after an active run
  always_comb begin
    case (eav_pat)
      5'b11110:          stage1_word = '1;
      5'b11100, 5'b11000: stage1_word = '0;
      5'b10000:          stage1_word = eav_word;
      default:           stage1_word = data_p;
    endcase
  end

  // SAV preamble over the last blank words before an active run
  always_comb begin
    case (sav_pat)
      5'b00001:          out_word = '1;
      5'b00011, 5'b00111: out_word = '0;
      5'b01111:          out_word = sav_word;
      default:           out_word = data_dly[5];
    endcase
  end

  always_ff @(posedge hdmi_clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_dly     <= '0;
      vs_dly     <= '0;
      data_dly   <= '0;
      hdmi_hs_de <= 1'b0;
      hdmi_vs_de <= 1'b0;
      hdmi_data  <= '0;
    end else begin
      hs_dly        <= {hs_dly[4:1], hs_de_p};
      vs_dly        <= {vs_dly[4:1], vs_de_p};
      data_dly[1]   <= stage1_word;
      data_dly[5:2] <= data_dly[4:1];
      hdmi_hs_de    <= hs_dly[5];
      hdmi_vs_de    <= vs_dly[5];
      hdmi_data     <= out_word;
    end
  end

  // Active words pass both insertion stages untouched
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    hs_de_p |=> data_dly[1] == $past(data_p))
    else $error("active word overwritten at first stage");

  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    hs_dly[5] |=> hdmi_hs_de && hdmi_data == $past(data_dly[5]))
    else $error("active word overwritten at final stage");

  // EAV sequence at the first stage
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    eav_pat == 5'b11110 |=> data_dly[1] == '1 ##1 data_dly[1] == '0
      ##1 data_dly[1] == '0 ##1 data_dly[1] == $past(eav_word))
    else $error("EAV preamble not written at first stage");

  // SAV sequence at the final stage
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    sav_pat == 5'b00001 |=> hdmi_data == '1 ##1 hdmi_data == '0
      ##1 hdmi_data == '0 ##1 hdmi_data == $past(sav_word))
    else $error("SAV preamble not written at final stage");

  // EAV reaches the output intact with the code of its line
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    eav_pat == 5'b10000 |=> ##5 (!hdmi_hs_de && hdmi_data == hdmi_tx_pkg::fill_byte(
      hdmi_vs_de ? hdmi_tx_pkg::EAV_ACTIVE : hdmi_tx_pkg::EAV_BLANK)))
    else $error("EAV word does not match vertical enable");

  // SAV code matches the line that follows it
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    sav_pat == 5'b01111 |=> ##1 (hdmi_hs_de && $past(hdmi_data) == hdmi_tx_pkg::fill_byte(
      hdmi_vs_de ? hdmi_tx_pkg::SAV_ACTIVE : hdmi_tx_pkg::SAV_BLANK)))
    else $error("SAV word does not match vertical enable");

endmodule

// ==== rtl/hdmi_tx_pkg.sv ====
/* Pattern mode type, blanking word, colour bar table and sync code bytes */

`include "hdmi_tx_settings.svh"

package hdmi_tx_pkg;

  typedef enum logic [1:0] {
    PAT_BARS     = 2'd0,
    PAT_RAMP     = 2'd1,
    PAT_SOLID    = 2'd2,
    PAT_INV_RAMP = 2'd3
  } pattern_mode_t;

  // Blanking level from the byte pair 80 10
  localparam logic [`HDMI_DATA_WIDTH-1:0] BLANK_WORD = {(`HDMI_DATA_WIDTH/16){8'h80, 8'h10}};

  // Kept inside 01..FE
  localparam logic [7:0] BAR_TABLE [0:7] = '{
    8'heb, 8'hd2, 8'haa, 8'h91, 8'h6a, 8'h51, 8'h29, 8'h10
  };

  localparam logic [7:0] SAV_ACTIVE = 8'h80;
  localparam logic [7:0] SAV_BLANK  = 8'hab;
  localparam logic [7:0] EAV_ACTIVE = 8'h9d;
  localparam logic [7:0] EAV_BLANK  = 8'hb6;

  function automatic logic [`HDMI_DATA_WIDTH-1:0] fill_byte(input logic [7:0] value);
    return {(`HDMI_DATA_WIDTH/8){value}};
  endfunction

endpackage

// ==== rtl/hdmi_tx_settings.svh ====
/* Data width and frame geometry macros for the HDMI transmit path */

`ifndef HDMI_TX_SETTINGS_SVH
`define HDMI_TX_SETTINGS_SVH

// Video word width in multiples of 8 bits
`define HDMI_DATA_WIDTH 32

// Horizontal geometry in words
// Blanking must leave room for both preambles
`define HDMI_H_ACTIVE   16
`define HDMI_H_TOTAL    28

// Vertical geometry in lines
`define HDMI_V_ACTIVE   4
`define HDMI_V_TOTAL    6

`define HDMI_H_CNT_W    5
`define HDMI_V_CNT_W    3

`endif

// ==== rtl/hdmi_tx_top.sv ====
/* HDMI transmit video path top level
   Timing generator, test pattern generator and embedded sync inserter */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module hdmi_tx_top (
  input  logic                        hdmi_clk,
  input  logic                        rst_n,
  input  logic                        enable,
  input  hdmi_tx_pkg::pattern_mode_t  mode,
  input  logic [`HDMI_DATA_WIDTH-1:0] solid_color,
  output logic [`HDMI_DATA_WIDTH-1:0] hdmi_data,
  output logic                        hdmi_hs_de,
  output logic                        hdmi_vs_de
);

  video_timing_if timing_bus ();

  logic                        hs_de_p;
  logic                        vs_de_p;
  logic [`HDMI_DATA_WIDTH-1:0] data_p;

  video_timing_gen video_timing_gen_inst (
    .hdmi_clk (hdmi_clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .timing   (timing_bus.source)
  );

  test_pattern_gen test_pattern_gen_inst (
    .hdmi_clk    (hdmi_clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .solid_color (solid_color),
    .timing      (timing_bus.sink),
    .hs_de_p     (hs_de_p),
    .vs_de_p     (vs_de_p),
    .data_p      (data_p)
  );

  // Six cycles from data_p to the output ports
  embedded_sync_inserter embedded_sync_inserter_inst (
    .hdmi_clk   (hdmi_clk),
    .rst_n      (rst_n),
    .hs_de_p    (hs_de_p),
    .vs_de_p    (vs_de_p),
    .data_p     (data_p),
    .hdmi_hs_de (hdmi_hs_de),
    .hdmi_vs_de (hdmi_vs_de),
    .hdmi_data  (hdmi_data)
  );

endmodule

// ==== rtl/test_pattern_gen.sv ====
/* Test pattern generator with byte clamping and blanking fill */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module test_pattern_gen (
  input  logic                          hdmi_clk,
  input  logic                          rst_n,
  input  hdmi_tx_pkg::pattern_mode_t    mode,
  input  logic [`HDMI_DATA_WIDTH-1:0]   solid_color,
  video_timing_if.sink                  timing,
  output logic                          hs_de_p,
  output logic                          vs_de_p,
  output logic [`HDMI_DATA_WIDTH-1:0]   data_p
);

  localparam int BYTES = `HDMI_DATA_WIDTH / 8;
  localparam logic [`HDMI_H_CNT_W+2:0] BAR_DIV = `HDMI_H_ACTIVE;

  logic [`HDMI_H_CNT_W+2:0]   bar_pos;
  logic [2:0]                 bar_index;
  logic [7:0]                 ramp_byte;
  logic [`HDMI_DATA_WIDTH-1:0] pattern_word;
  logic [`HDMI_DATA_WIDTH-1:0] clamped_word;
  logic                       active;

  // Keep pixels off the 00 and FF sync bytes
  function automatic logic [7:0] clamp_byte(input logic [7:0] value);
    if (value == 8'h00) begin
      return 8'h01;
    end
    if (value == 8'hff) begin
      return 8'hfe;
    end
    return value;
  endfunction

  assign active = timing.hs_de & timing.vs_de;

  // Eight bars across the active width
  assign bar_pos   = {timing.h_count, 3'b000} / BAR_DIV;
  assign bar_index = bar_pos[2:0];

  assign ramp_byte = 8'(timing.h_count) + 8'({timing.v_count, 4'b0000});

  always_comb begin
    case (mode)
      hdmi_tx_pkg::PAT_BARS: begin
        pattern_word = hdmi_tx_pkg::fill_byte(hdmi_tx_pkg::BAR_TABLE[bar_index]);
      end
      hdmi_tx_pkg::PAT_RAMP: begin
        pattern_word = hdmi_tx_pkg::fill_byte(ramp_byte);
      end
      hdmi_tx_pkg::PAT_SOLID: begin
        pattern_word = solid_color;
      end
      default: begin
        pattern_word = hdmi_tx_pkg::fill_byte(8'hff - ramp_byte);
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < BYTES; i++) begin
      clamped_word[8*i +: 8] = clamp_byte(pattern_word[8*i +: 8]);
    end
  end

  always_ff @(posedge hdmi_clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_de_p <= 1'b0;
      vs_de_p <= 1'b0;
      data_p  <= '0;
    end else begin
      hs_de_p <= timing.hs_de;
      vs_de_p <= timing.vs_de;
      data_p  <= active ? clamped_word : hdmi_tx_pkg::BLANK_WORD;
    end
  end

endmodule

// ==== rtl/video_timing_gen.sv ====
/* Horizontal and vertical counters with registered data enables */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module video_timing_gen (
  input logic            hdmi_clk,
  input logic            rst_n,
  input logic            enable,
  video_timing_if.source timing
);

  localparam logic [`HDMI_H_CNT_W-1:0] H_LAST   = `HDMI_H_TOTAL - 1;
  localparam logic [`HDMI_V_CNT_W-1:0] V_LAST   = `HDMI_V_TOTAL - 1;
  localparam logic [`HDMI_H_CNT_W-1:0] H_ACTIVE = `HDMI_H_ACTIVE;
  localparam logic [`HDMI_V_CNT_W-1:0] V_ACTIVE = `HDMI_V_ACTIVE;

  logic [`HDMI_H_CNT_W-1:0] h_count_next;
  logic [`HDMI_V_CNT_W-1:0] v_count_next;
  logic                     h_wrap;

  assign h_wrap = (timing.h_count == H_LAST);

  always_comb begin
    h_count_next = timing.h_count;
    v_count_next = timing.v_count;
    if (enable) begin
      if (h_wrap) begin
        h_count_next = '0;
        // Line step on wrap
        if (timing.v_count == V_LAST) begin
          v_count_next = '0;
        end else begin
          v_count_next = timing.v_count + 1'b1;
        end
      end else begin
        h_count_next = timing.h_count + 1'b1;
      end
    end
  end

  // Enables follow the next counts so they line up with the counters
  always_ff @(posedge hdmi_clk or negedge rst_n) begin
    if (!rst_n) begin
      timing.h_count <= '0;
      timing.v_count <= '0;
      timing.hs_de   <= 1'b0;
      timing.vs_de   <= 1'b0;
    end else begin
      timing.h_count <= h_count_next;
      timing.v_count <= v_count_next;
      timing.hs_de   <= (h_count_next < H_ACTIVE);
      timing.vs_de   <= (v_count_next < V_ACTIVE);
    end
  end

  // Counter ranges
  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    timing.h_count < `HDMI_H_TOTAL)
    else $error("h_count out of range");

  assert property (@(posedge hdmi_clk) disable iff (!rst_n)
    timing.v_count < `HDMI_V_TOTAL)
    else $error("v_count out of range");

endmodule

// ==== rtl/video_timing_if.sv ====
/* Timing counts and data enables from the timing generator */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

interface video_timing_if;

  logic [`HDMI_H_CNT_W-1:0] h_count;
  logic [`HDMI_V_CNT_W-1:0] v_count;
  logic                     hs_de;
  logic                     vs_de;

  modport source (
    output h_count, v_count, hs_de, vs_de
  );

  modport sink (
    input h_count, v_count, hs_de, vs_de
  );

endinterface

// ==== testbench/hdmi_tx_checker.sv ====
/* Reference model of the HDMI transmit stream, 7-cycle expected-value pipeline
   and comparison of the top level outputs */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module hdmi_tx_checker (
  input  logic                        hdmi_clk,
  input  logic                        rst_n,
  input  logic                        enable,
  input  hdmi_tx_pkg::pattern_mode_t  mode,
  input  logic [`HDMI_DATA_WIDTH-1:0] solid_color,
  input  logic [`HDMI_DATA_WIDTH-1:0] hdmi_data,
  input  logic                        hdmi_hs_de,
  input  logic                        hdmi_vs_de,
  output int                          data_error_count,
  output int                          de_error_count,
  output int                          checked_count
);

  localparam int W        = `HDMI_DATA_WIDTH;
  localparam int H_ACTIVE = `HDMI_H_ACTIVE;
  localparam int H_TOTAL  = `HDMI_H_TOTAL;
  localparam int V_ACTIVE = `HDMI_V_ACTIVE;
  localparam int V_TOTAL  = `HDMI_V_TOTAL;
  localparam int LATENCY  = 7;

  int h_pos;
  int v_pos;
  logic started;

  logic [W-1:0] exp_data_q [0:LATENCY-1];
  logic         exp_hs_q   [0:LATENCY-1];
  logic         exp_vs_q   [0:LATENCY-1];
  logic         exp_valid_q[0:LATENCY-1];
  int           mode_q     [0:LATENCY-1];
  int           h_q        [0:LATENCY-1];
  int           v_q        [0:LATENCY-1];

  int data_errors = 0;
  int de_errors = 0;
  int words_checked = 0;

  assign data_error_count = data_errors;
  assign de_error_count   = de_errors;
  assign checked_count    = words_checked;

  function automatic logic [W-1:0] replicate_byte(input logic [7:0] value);
    logic [W-1:0] word;
    for (int i = 0; i < W / 8; i++) begin
      word[8*i +: 8] = value;
    end
    return word;
  endfunction

  // No active byte may look like a sync byte
  function automatic logic [W-1:0] clamp_word(input logic [W-1:0] word);
    logic [W-1:0] result;
    result = word;
    for (int i = 0; i < W / 8; i++) begin
      if (word[8*i +: 8] == 8'h00) begin
        result[8*i +: 8] = 8'h01;
      end else if (word[8*i +: 8] == 8'hff) begin
        result[8*i +: 8] = 8'hfe;
      end
    end
    return result;
  endfunction

  // Expected output word for one count position
  function automatic logic [W-1:0] expected_word(input int h, input int v,
                                                 input hdmi_tx_pkg::pattern_mode_t pmode,
                                                 input logic [W-1:0] color);
    logic [7:0] ramp;
    logic [W-1:0] word;
    int next_v;
    next_v = (v + 1) % V_TOTAL;
    ramp = 8'(h + 16 * v);
    if (h == H_ACTIVE || h == H_TOTAL - 4) begin
      word = '1;
    end else if (h == H_ACTIVE + 1 || h == H_ACTIVE + 2 ||
                 h == H_TOTAL - 3 || h == H_TOTAL - 2) begin
      word = '0;
    end else if (h == H_ACTIVE + 3) begin
      word = replicate_byte(v < V_ACTIVE ? hdmi_tx_pkg::EAV_ACTIVE : hdmi_tx_pkg::EAV_BLANK);
    end else if (h == H_TOTAL - 1) begin
      // SAV announces the line that follows
      word = replicate_byte(next_v < V_ACTIVE ? hdmi_tx_pkg::SAV_ACTIVE
                                              : hdmi_tx_pkg::SAV_BLANK);
    end else if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      word = hdmi_tx_pkg::BLANK_WORD;
    end else begin
      case (pmode)
        hdmi_tx_pkg::PAT_BARS:  word = replicate_byte(hdmi_tx_pkg::BAR_TABLE[(h * 8) / H_ACTIVE]);
        hdmi_tx_pkg::PAT_RAMP:  word = replicate_byte(ramp);
        hdmi_tx_pkg::PAT_SOLID: word = color;
        default:                word = replicate_byte(8'hff - ramp);
      endcase
      word = clamp_word(word);
    end
    return word;
  endfunction

  // Counter copy and expected-value pipeline
  always @(posedge hdmi_clk or negedge rst_n) begin
    if (!rst_n) begin
      h_pos   <= 0;
      v_pos   <= 0;
      started <= 1'b0;
      for (int k = 0; k < LATENCY; k++) begin
        exp_data_q[k]  <= '0;
        exp_hs_q[k]    <= 1'b0;
        exp_vs_q[k]    <= 1'b0;
        exp_valid_q[k] <= 1'b0;
        mode_q[k]      <= 0;
        h_q[k]         <= 0;
        v_q[k]         <= 0;
      end
    end else begin
      exp_data_q[0]  <= expected_word(h_pos, v_pos, mode, solid_color);
      // First position after reset still carries the reset enables
      exp_hs_q[0]    <= started && (h_pos < H_ACTIVE);
      exp_vs_q[0]    <= started && (v_pos < V_ACTIVE);
      exp_valid_q[0] <= started;
      mode_q[0]      <= int'(mode);
      h_q[0]         <= h_pos;
      v_q[0]         <= v_pos;
      for (int k = 1; k < LATENCY; k++) begin
        exp_data_q[k]  <= exp_data_q[k-1];
        exp_hs_q[k]    <= exp_hs_q[k-1];
        exp_vs_q[k]    <= exp_vs_q[k-1];
        exp_valid_q[k] <= exp_valid_q[k-1];
        mode_q[k]      <= mode_q[k-1];
        h_q[k]         <= h_q[k-1];
        v_q[k]         <= v_q[k-1];
      end
      started <= 1'b1;
      if (enable) begin
        if (h_pos == H_TOTAL - 1) begin
          h_pos <= 0;
          v_pos <= (v_pos + 1) % V_TOTAL;
        end else begin
          h_pos <= h_pos + 1;
        end
      end
    end
  end

  always @(posedge hdmi_clk) begin
    if (rst_n) begin
      if (hdmi_hs_de !== exp_hs_q[LATENCY-1] || hdmi_vs_de !== exp_vs_q[LATENCY-1]) begin
        de_errors++;
        $display("mismatch at %0d ns: enables at h=%0d v=%0d expected hs=%b vs=%b, got hs=%b vs=%b",
                 $time, h_q[LATENCY-1], v_q[LATENCY-1], exp_hs_q[LATENCY-1],
                 exp_vs_q[LATENCY-1], hdmi_hs_de, hdmi_vs_de);
      end
      if (exp_valid_q[LATENCY-1]) begin
        words_checked++;
        if (hdmi_data !== exp_data_q[LATENCY-1]) begin
          data_errors++;
          $display("mismatch at %0d ns: data at h=%0d v=%0d mode=%0d expected %h, got %h",
                   $time, h_q[LATENCY-1], v_q[LATENCY-1], mode_q[LATENCY-1],
                   exp_data_q[LATENCY-1], hdmi_data);
        end
      end
    end
  end

endmodule

// ==== testbench/hdmi_tx_tb.sv ====
/* Testbench top with clock, reset, mode stimulus, DUT, checker and timeout */

`timescale 1ns/100ps
`include "hdmi_tx_settings.svh"

module hdmi_tx_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int FRAME_CYCLES   = `HDMI_H_TOTAL * `HDMI_V_TOTAL;
  localparam int NUM_FRAMES     = 4;
  localparam int DRAIN_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 50;

  logic                        hdmi_clk;
  logic                        rst_n;
  logic                        enable;
  hdmi_tx_pkg::pattern_mode_t  mode;
  logic [`HDMI_DATA_WIDTH-1:0] solid_color;
  logic [`HDMI_DATA_WIDTH-1:0] hdmi_data;
  logic                        hdmi_hs_de;
  logic                        hdmi_vs_de;

  int seed;
  int cycle_count = 0;
  int data_errors;
  int de_errors;
  int words_checked;

  hdmi_tx_top hdmi_tx_top_inst (
    .hdmi_clk    (hdmi_clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .mode        (mode),
    .solid_color (solid_color),
    .hdmi_data   (hdmi_data),
    .hdmi_hs_de  (hdmi_hs_de),
    .hdmi_vs_de  (hdmi_vs_de)
  );

  hdmi_tx_checker hdmi_tx_checker_inst (
    .hdmi_clk         (hdmi_clk),
    .rst_n            (rst_n),
    .enable           (enable),
    .mode             (mode),
    .solid_color      (solid_color),
    .hdmi_data        (hdmi_data),
    .hdmi_hs_de       (hdmi_hs_de),
    .hdmi_vs_de       (hdmi_vs_de),
    .data_error_count (data_errors),
    .de_error_count   (de_errors),
    .checked_count    (words_checked)
  );

  always #(CLK_PERIOD / 2) hdmi_clk = ~hdmi_clk;

  task automatic print_counts();
    $display("errors: data %0d, enable %0d; words checked %0d",
             data_errors, de_errors, words_checked);
  endtask

  // Mode steps once per frame in its last cycle
  initial begin
    hdmi_clk    = 1'b0;
    rst_n       = 1'b0;
    enable      = 1'b0;
    mode        = hdmi_tx_pkg::PAT_BARS;
    seed        = 46381;
    solid_color = $random(seed);
    repeat (2) @(posedge hdmi_clk);
    rst_n  <= 1'b1;
    enable <= 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      repeat (FRAME_CYCLES - 1) @(posedge hdmi_clk);
      mode        <= hdmi_tx_pkg::pattern_mode_t'(mode + 2'd1);
      solid_color <= $random(seed);
      @(posedge hdmi_clk);
    end
    repeat (DRAIN_CYCLES) @(posedge hdmi_clk);
    print_counts();
    if (data_errors == 0 && de_errors == 0 && words_checked > 0) begin
      $display("Everything OK");
    end else begin
      if (words_checked == 0) begin
        $display("No output words were compared");
      end
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge hdmi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("Something failed");
      $finish;
    end
  end

endmodule
